// File: source/readout_pkg.sv
/*
 * Shared widths, FIFO depths and payload types of the hit readout.
 * FIFO capacity is one less than the depth given here.
 * The readout word layout is built in readout_mux from these widths.
 */
package readout_pkg;

    // Hit and counter widths.
    localparam int channel_width    = 4;
    localparam int timestamp_width  = 16;
    localparam int drop_count_width = 16;

    // Width of the word seen by the external reader.
    localparam int word_width = 32;

    // Buffer depths, usable entries are depth minus one.
    localparam int hit_fifo_depth    = 8;
    localparam int status_fifo_depth = 4;

    // One accepted hit, 20 bits.
    typedef struct packed {
        logic [channel_width-1:0]   channel;
        logic [timestamp_width-1:0] timestamp;
    } hit_word_t;

    // Status record carrying the number of dropped hits.
    typedef struct packed {
        logic [drop_count_width-1:0] dropped;
    } status_word_t;

endpackage

// File: source/fifo_rd_if.sv
/*
 * Read side of a FIFO. Data is valid whenever empty is low.
 * A read while empty is high is ignored by the FIFO.
 * DEPTH must match the FIFO so that level has the right width.
 */
`timescale 1ns/1ps

interface fifo_rd_if #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
);

    localparam int level_width = $clog2(DEPTH);

    payload_t               data;
    logic                   empty;
    logic [level_width-1:0] level;
    logic                   read;

    modport fifo (
        output data, empty, level,
        input  read
    );

    modport reader (
        input  data, empty, level,
        output read
    );

endinterface

// File: source/hit_encoder.sv
/*
 * Timestamps hits and feeds the hit and status FIFOs.
 * A hit is written one cycle after it is sampled, or dropped if the hit FIFO is full.
 * The drop counter saturates and is flushed only while neither FIFO is full.
 */
`timescale 1ns/1ps

module hit_encoder
    import readout_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     hit,
    input  logic [channel_width-1:0] hit_channel,
    input  logic                     hit_full,
    output logic                     hit_write,
    output hit_word_t                hit_data,
    input  logic                     status_full,
    output logic                     status_write,
    output status_word_t             status_data
);

    logic [timestamp_width-1:0]  timestamp;
    logic                        capture_valid;
    hit_word_t                   capture;
    logic [drop_count_width-1:0] drop_count;
    logic                        drop;

    // Free-running timestamp, zero in the first cycle out of reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    // One-stage capture of the hit and the stamp at the same edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            capture_valid <= 1'b0;
        end else begin
            capture_valid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            capture.channel   <= hit_channel;
            capture.timestamp <= timestamp;
        end
    end

    assign hit_write = capture_valid && !hit_full;
    assign hit_data  = capture;
    assign drop      = capture_valid && hit_full;

    // Flush the count whenever both buffers have room.
    assign status_write        = (drop_count != '0) && !hit_full && !status_full;
    assign status_data.dropped = drop_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (status_write) begin
            // A drop in the flush cycle starts the next count.
            drop_count <= drop_count_width'(drop);
        end else if (drop && drop_count != '1) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

// File: source/generic_fifo.sv
/*
 * Circular-buffer FIFO holding DEPTH minus one words of payload_t.
 * Empty and data are registered, full and level are combinational.
 * A word written at one edge is readable after the next edge at the earliest.
 * Writes while full and reads while empty are ignored.
 */
`timescale 1ns/1ps

module generic_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      write,
    input  payload_t  data_in,
    output logic      full,
    fifo_rd_if.fifo   rd
);

    localparam int ptr_width = $clog2(DEPTH);
    localparam logic [ptr_width-1:0] last_addr = ptr_width'(DEPTH - 1);

    payload_t               mem [DEPTH];
    logic [ptr_width-1:0]   rd_ptr;
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_succ;
    logic [ptr_width-1:0]   wr_succ;
    logic [ptr_width-1:0]   rd_next;
    logic                   do_read;
    logic                   do_write;

    // Pointer step with wrap at DEPTH.
    function automatic logic [ptr_width-1:0] advance(input logic [ptr_width-1:0] ptr);
        return (ptr == last_addr) ? '0 : ptr + 1'b1;
    endfunction

    assign do_read  = rd.read && !rd.empty;
    assign do_write = write && !full;

    assign rd_succ = advance(rd_ptr);
    assign wr_succ = advance(wr_ptr);

    // Look-ahead read address for the output register.
    assign rd_next = do_read ? rd_succ : rd_ptr;

    // One slot stays unused so that full and empty differ.
    assign full = (wr_succ == rd_ptr);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_succ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_succ;
        end
    end

    // Empty follows the pointers one cycle late.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd.empty <= 1'b1;
        end else if (do_read) begin
            rd.empty <= (wr_ptr == rd_succ);
        end else begin
            rd.empty <= (wr_ptr == rd_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Reloaded every cycle, so the next word follows a pop directly.
    always_ff @(posedge clk) begin
        rd.data <= mem[rd_next];
    end

    // Fill level from the pointer difference.
    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            rd.level = wr_ptr - rd_ptr;
        end else begin
            rd.level = last_addr - rd_ptr + wr_ptr + 1'b1;
        end
    end

endmodule

// File: source/readout_mux.sv
/*
 * Merges status and hit FIFOs into one tagged 32-bit readout word.
 * The word sits in a one-entry output register, adding a cycle of latency.
 * Status priority applies to words not yet loaded into that register.
 */
`timescale 1ns/1ps

module readout_mux
    import readout_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    fifo_rd_if.reader             status_rd,
    fifo_rd_if.reader             hit_rd,
    input  logic                  read,
    output logic [word_width-1:0] readout_word,
    output logic                  readout_empty
);

    logic                  load;
    logic [word_width-1:0] next_word;

    // Refill when the register is free or being popped.
    assign load = (readout_empty || read) && (!status_rd.empty || !hit_rd.empty);

    // Strobe goes only to the chosen source.
    assign status_rd.read = load && !status_rd.empty;
    assign hit_rd.read    = load && status_rd.empty;

    // Tag bit 31 marks a status word.
    always_comb begin
        next_word = '0;
        if (!status_rd.empty) begin
            next_word[word_width-1]         = 1'b1;
            next_word[drop_count_width-1:0] = status_rd.data.dropped;
        end else begin
            next_word[timestamp_width +: channel_width] = hit_rd.data.channel;
            next_word[timestamp_width-1:0]              = hit_rd.data.timestamp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readout_empty <= 1'b1;
        end else if (load) begin
            readout_empty <= 1'b0;
        end else if (read) begin
            readout_empty <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            readout_word <= next_word;
        end
    end

endmodule

// File: source/hit_readout.sv
/*
 * Hit readout buffer top level, one clock domain.
 * Hits beyond the free space of the hit FIFO are dropped and reported as status words.
 * hit_fill_level lets the outside throttle before drops happen.
 */
`timescale 1ns/1ps

module hit_readout
    import readout_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               hit,
    input  logic [channel_width-1:0]           hit_channel,
    input  logic                               read,
    output logic [word_width-1:0]              readout_word,
    output logic                               readout_empty,
    output logic [$clog2(hit_fifo_depth)-1:0]  hit_fill_level
);

    logic         hit_write;
    logic         hit_full;
    hit_word_t    hit_data;
    logic         status_write;
    logic         status_full;
    status_word_t status_data;

    fifo_rd_if #(.payload_t(hit_word_t), .DEPTH(hit_fifo_depth)) hit_rd ();
    fifo_rd_if #(.payload_t(status_word_t), .DEPTH(status_fifo_depth)) status_rd ();

    hit_encoder encoder (
        .clk          (clk),
        .reset        (reset),
        .hit          (hit),
        .hit_channel  (hit_channel),
        .hit_full     (hit_full),
        .hit_write    (hit_write),
        .hit_data     (hit_data),
        .status_full  (status_full),
        .status_write (status_write),
        .status_data  (status_data)
    );

    generic_fifo #(.payload_t(hit_word_t), .DEPTH(hit_fifo_depth)) hit_fifo (
        .clk     (clk),
        .reset   (reset),
        .write   (hit_write),
        .data_in (hit_data),
        .full    (hit_full),
        .rd      (hit_rd.fifo)
    );

    generic_fifo #(.payload_t(status_word_t), .DEPTH(status_fifo_depth)) status_fifo (
        .clk     (clk),
        .reset   (reset),
        .write   (status_write),
        .data_in (status_data),
        .full    (status_full),
        .rd      (status_rd.fifo)
    );

    readout_mux mux (
        .clk           (clk),
        .reset         (reset),
        .status_rd     (status_rd.reader),
        .hit_rd        (hit_rd.reader),
        .read          (read),
        .readout_word  (readout_word),
        .readout_empty (readout_empty)
    );

    assign hit_fill_level = hit_rd.level;

endmodule

// File: testbench/hit_readout_checker.sv
/*
 * Concurrent checks on every generic_fifo instance, attached by bind.
 * The bind passes the payload type and DEPTH of each FIFO through.
 */
`timescale 1ns/1ps

module hit_readout_checker #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     write,
    input logic                     full,
    input logic                     empty,
    input logic [$clog2(DEPTH)-1:0] level,
    input logic                     read,
    input payload_t                 data
);

    // Flags are exclusive.
    never_empty_and_full: assert property (
        @(posedge clk) disable iff (reset) !(empty && full)
    ) else $error("FIFO reports empty and full in the same cycle.");

    // Level moves only with accepted writes and reads.
    level_tracks_strobes: assert property (
        @(posedge clk) disable iff (reset)
        int'(level) == int'($past(level)) + int'($past(write && !full))
                       - int'($past(read && !empty))
    ) else $error("FIFO level does not follow the accepted writes and reads.");

    empty_after_reset: assert property (
        @(posedge clk) reset |=> empty
    ) else $error("FIFO is not empty in the cycle after reset.");

    // Front word holds until it is popped.
    data_held: assert property (
        @(posedge clk) disable iff (reset) (!empty && !read) |=> $stable(data)
    ) else $error("FIFO data changed without a read.");

endmodule

bind generic_fifo hit_readout_checker #(
    .payload_t (payload_t),
    .DEPTH     (DEPTH)
) fifo_checker (
    .clk   (clk),
    .reset (reset),
    .write (write),
    .full  (full),
    .empty (rd.empty),
    .level (rd.level),
    .read  (rd.read),
    .data  (rd.data)
);

// File: testbench/hit_readout_tb.sv
/*
 * Self-checking testbench for hit_readout, LFSR stimulus with seed 18.
 * The model tracks both FIFO occupancies and the readout register per cycle.
 * The run stops at the first mismatch.
 */
`timescale 1ns/1ps

module hit_readout_tb
    import readout_pkg::*;
();

    localparam int clk_period    = 20;
    localparam int reset_cycles  = 5;
    localparam int sparse_cycles = 300;
    localparam int settle_cycles = 20;
    localparam int stall_cycles  = 20;
    localparam int drain_cycles  = 200;
    localparam int block_cycles  = 250;
    localparam int random_blocks = 16;
    localparam int margin_cycles = 100;
    localparam int run_cycles    = reset_cycles + sparse_cycles + 2 * settle_cycles
                                   + stall_cycles + 2 * drain_cycles
                                   + random_blocks * block_cycles;

    logic                              clk = 1'b0;
    logic                              reset;
    logic                              hit;
    logic [channel_width-1:0]          hit_channel;
    logic                              read;
    logic [word_width-1:0]             readout_word;
    logic                              readout_empty;
    logic [$clog2(hit_fifo_depth)-1:0] hit_fill_level;

    logic [15:0]                 lfsr = 16'd18;
    logic [timestamp_width-1:0]  model_ts;
    logic                        cap_valid;
    hit_word_t                   cap_word;
    logic                        out_empty;
    logic                        out_status;
    logic                        hit_empty;
    logic                        status_empty;
    int                          hit_occ;
    int                          status_occ;
    int                          drop_count;
    int                          hits_driven;
    int                          hits_popped;
    int                          drops_reported;
    hit_word_t                   hit_queue[$];
    logic [drop_count_width-1:0] status_queue[$];

    hit_readout uut (
        .clk            (clk),
        .reset          (reset),
        .hit            (hit),
        .hit_channel    (hit_channel),
        .read           (read),
        .readout_word   (readout_word),
        .readout_empty  (readout_empty),
        .hit_fill_level (hit_fill_level)
    );

    always #(clk_period / 2) clk = ~clk;

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[14:0], lfsr[0]};
        end
        return value;
    endfunction

    // True with odds of one in 2**shift, never for a negative shift.
    function automatic logic chance(input int shift);
        if (shift < 0) begin
            return 1'b0;
        end
        return random_bits(shift) == '0;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Stopping at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR at %0t ns: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    // Called right after a rising edge, so it sees the values sampled at that edge.
    task automatic update_model();
        logic                        hit_full_now;
        logic                        status_full_now;
        logic                        write_hit;
        logic                        drop;
        logic                        write_status;
        logic                        load;
        logic                        pop_status;
        logic                        pop_hit;
        hit_word_t                   hit_front;
        logic [drop_count_width-1:0] status_front;
        if (reset) begin
            model_ts     = '0;
            cap_valid    = 1'b0;
            drop_count   = 0;
            hit_occ      = 0;
            status_occ   = 0;
            hit_empty    = 1'b1;
            status_empty = 1'b1;
            out_empty    = 1'b1;
        end else begin
            check_value("readout_empty", 32'(out_empty), 32'(readout_empty));
            check_value("hit_fill_level", hit_occ, 32'(hit_fill_level));
            if (read && !out_empty) begin
                check_value("readout_word[31]", 32'(out_status), 32'(readout_word[31]));
                if (out_status) begin
                    if (status_queue.size() == 0) begin
                        fail_run("A status word was read while the model held no record.");
                    end else begin
                        status_front = status_queue.pop_front();
                        drops_reported += int'(status_front);
                        check_value("readout_word", {1'b1, 15'h0000, status_front},
                                    readout_word);
                    end
                end else if (hit_queue.size() == 0) begin
                    fail_run("A hit word was read while the model held no accepted hit.");
                end else begin
                    hit_front = hit_queue.pop_front();
                    hits_popped++;
                    check_value("readout_word",
                                {12'h000, hit_front.channel, hit_front.timestamp},
                                readout_word);
                end
            end
            // Encoder writes, drops and status flush.
            hit_full_now    = (hit_occ == hit_fifo_depth - 1);
            status_full_now = (status_occ == status_fifo_depth - 1);
            write_hit       = cap_valid && !hit_full_now;
            drop            = cap_valid && hit_full_now;
            write_status    = (drop_count != 0) && !hit_full_now && !status_full_now;
            if (write_hit) begin
                hit_queue.push_back(cap_word);
            end
            if (write_status) begin
                status_queue.push_back(drop_count_width'(drop_count));
                drop_count = drop ? 1 : 0;
            end else if (drop && drop_count < 65535) begin
                drop_count++;
            end
            // Readout register refill, status first.
            load       = (out_empty || read) && !(hit_empty && status_empty);
            pop_status = load && !status_empty;
            pop_hit    = load && status_empty;
            hit_occ    = hit_occ - (pop_hit ? 1 : 0);
            status_occ = status_occ - (pop_status ? 1 : 0);
            hit_empty    = (hit_occ == 0);
            status_empty = (status_occ == 0);
            hit_occ    = hit_occ + (write_hit ? 1 : 0);
            status_occ = status_occ + (write_status ? 1 : 0);
            if (load) begin
                out_status = pop_status;
                out_empty  = 1'b0;
            end else if (read) begin
                out_empty = 1'b1;
            end
            cap_valid = hit;
            if (hit) begin
                cap_word.channel   = hit_channel;
                cap_word.timestamp = model_ts;
                hits_driven++;
            end
            model_ts = model_ts + 1'b1;
        end
    endtask

    task automatic run_phase(input int cycles, input int hit_shift, input int read_shift);
        logic [15:0] channel_bits;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            update_model();
            channel_bits = random_bits(channel_width);
            hit         <= chance(hit_shift);
            hit_channel <= channel_bits[channel_width-1:0];
            read        <= chance(read_shift);
        end
    endtask

    initial begin
        #((run_cycles + margin_cycles) * clk_period);
        fail_run("Watchdog timeout: the run did not finish in the expected time.");
    end

    initial begin
        reset       = 1'b1;
        hit         = 1'b0;
        hit_channel = '0;
        read        = 1'b0;
        repeat (reset_cycles) begin
            @(posedge clk);
            update_model();
        end
        reset <= 1'b0;
        @(negedge clk);
        check_value("readout_empty", 1, 32'(readout_empty));
        check_value("hit_fill_level", 0, 32'(hit_fill_level));

        // Sparse hits with a reader that never stops, so nothing is dropped.
        run_phase(sparse_cycles, 3, 0);
        run_phase(settle_cycles, -1, 0);
        check_value("status records", 0, drops_reported + status_queue.size());

        // Reader stalled. Seven FIFO entries plus the readout register fill up.
        run_phase(stall_cycles, 0, -1);
        run_phase(settle_cycles, -1, -1);
        @(negedge clk);
        check_value("hit_fill_level", hit_fifo_depth - 1, 32'(hit_fill_level));
        check_value("pending drops", stall_cycles - hit_fifo_depth, drop_count);
        run_phase(drain_cycles, -1, 0);
        check_value("reported drops", stall_cycles - hit_fifo_depth, drops_reported);

        // Mixed traffic with new odds every block.
        for (int b = 0; b < random_blocks; b++) begin
            run_phase(block_cycles, int'(random_bits(2)), int'(random_bits(2)));
        end
        run_phase(drain_cycles, -1, 0);
        @(negedge clk);
        check_value("readout_empty", 1, 32'(readout_empty));
        check_value("hit queue size", 0, hit_queue.size());
        check_value("status queue size", 0, status_queue.size());
        check_value("pending drops", 0, drop_count);
        check_value("hits accounted", hits_driven, hits_popped + drops_reported);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: all.f
source/readout_pkg.sv
source/fifo_rd_if.sv
source/hit_encoder.sv
source/generic_fifo.sv
source/readout_mux.sv
source/hit_readout.sv
testbench/hit_readout_checker.sv
testbench/hit_readout_tb.sv

// File: Makefile
# Verilator flow for the hit readout buffer.
VERILATOR  ?= verilator
FILE_LIST  ?= all.f
TB_TOP     ?= hit_readout_tb
RTL_TOP    ?= hit_readout
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
